// File: verilog/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// ADDI x0, x0, 0
`define NOP_INSTR   32'h0000_0013
`define RESET_PC    32'h0000_0000

// Major opcodes
`define OPC_LUI     7'b0110111
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// funct3 and funct7 values
`define F3_ADD_SUB  3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_WORD     3'b010
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F7_BASE     7'b0000000
`define F7_SUB      7'b0100000

`endif

// File: verilog/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [31:0]            instr_t;

    // Decoded operation, OP_NOP covers bubbles and anything unrecognized
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LUI,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage

// File: verilog/id_ex_if.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

interface id_ex_if;

    rv_pkg::op_t      op;
    rv_pkg::addr_t    pc;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    logic             rs1_used;
    logic             rs2_used;
    logic             rd_valid;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    rs1_value;
    rv_pkg::word_t    rs2_value;

    modport source (
        output op, pc, rs1, rs2, rd, rs1_used, rs2_used, rd_valid, imm, rs1_value, rs2_value
    );

    modport sink (
        input op, pc, rs1, rs2, rd, rs1_used, rs2_used, rd_valid, imm, rs1_value, rs2_value
    );

endinterface

// File: verilog/ex_mem_if.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

interface ex_mem_if;

    rv_pkg::op_t      op;
    rv_pkg::reg_idx_t rd;
    logic             rd_valid;
    // ALU result, link address, or memory address
    rv_pkg::word_t    result;
    rv_pkg::word_t    store_data;

    modport source (
        output op, rd, rd_valid, result, store_data
    );

    modport sink (
        input op, rd, rd_valid, result, store_data
    );

endinterface

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           rst,
    input  logic           load_stall,
    input  logic           redirect,
    input  rv_pkg::addr_t  redirect_pc,
    input  rv_pkg::instr_t instr_in,
    output rv_pkg::addr_t  pc,
    output rv_pkg::addr_t  if_pc,
    output rv_pkg::instr_t if_instr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!load_stall) begin
            pc <= pc + `XLEN'd4;
        end
    end

    // IF/ID register, bubble on reset or redirect, hold on stall
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            if_pc    <= '0;
            if_instr <= `NOP_INSTR;
        end else if (!load_stall) begin
            if_pc    <= pc;
            if_instr <= instr_in;
        end
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    output rv_pkg::word_t    rs1_value,
    output rv_pkg::word_t    rs2_value,
    input  logic             wr_en,
    input  rv_pkg::reg_idx_t wr_addr,
    input  rv_pkg::word_t    wr_value
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_value;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr_addr == addr) begin
            return wr_value;
        end
        return regs[addr];
    endfunction

    assign rs1_value = read_port(rs1_addr);
    assign rs2_value = read_port(rs2_addr);

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect,
    input  rv_pkg::addr_t    if_pc,
    input  rv_pkg::instr_t   if_instr,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_value,
    output logic             load_stall,
    id_ex_if.source          id_ex
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::op_t      op;
    rv_pkg::word_t    imm;
    logic             rs1_used;
    logic             rs2_used;
    logic             rd_valid;
    rv_pkg::word_t    rs1_value;
    rv_pkg::word_t    rs2_value;
    rv_pkg::reg_idx_t ex_rd;
    logic             ex_rd_valid;
    logic             ex_is_load;

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];

    always_comb begin
        op       = rv_pkg::OP_NOP;
        imm      = '0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        rd_valid = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                op       = rv_pkg::OP_LUI;
                imm      = {if_instr[31:12], 12'b0};
                rd_valid = 1'b1;
            end
            `OPC_OP_IMM: begin
                if (funct3 == `F3_ADD_SUB) begin
                    op       = rv_pkg::OP_ADDI;
                    imm      = {{20{if_instr[31]}}, if_instr[31:20]};
                    rs1_used = 1'b1;
                    rd_valid = 1'b1;
                end
            end
            `OPC_OP: begin
                case ({funct7, funct3})
                    {`F7_BASE, `F3_ADD_SUB}: op = rv_pkg::OP_ADD;
                    {`F7_SUB, `F3_ADD_SUB}:  op = rv_pkg::OP_SUB;
                    {`F7_BASE, `F3_AND}:     op = rv_pkg::OP_AND;
                    {`F7_BASE, `F3_OR}:      op = rv_pkg::OP_OR;
                    {`F7_BASE, `F3_XOR}:     op = rv_pkg::OP_XOR;
                    {`F7_BASE, `F3_SLT}:     op = rv_pkg::OP_SLT;
                    default:                 op = rv_pkg::OP_NOP;
                endcase
                rs1_used = (op != rv_pkg::OP_NOP);
                rs2_used = (op != rv_pkg::OP_NOP);
                rd_valid = (op != rv_pkg::OP_NOP);
            end
            `OPC_LOAD: begin
                if (funct3 == `F3_WORD) begin
                    op       = rv_pkg::OP_LW;
                    imm      = {{20{if_instr[31]}}, if_instr[31:20]};
                    rs1_used = 1'b1;
                    rd_valid = 1'b1;
                end
            end
            `OPC_STORE: begin
                if (funct3 == `F3_WORD) begin
                    op       = rv_pkg::OP_SW;
                    imm      = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                if (funct3 == `F3_BEQ || funct3 == `F3_BNE) begin
                    op       = (funct3 == `F3_BEQ) ? rv_pkg::OP_BEQ : rv_pkg::OP_BNE;
                    imm      = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                                if_instr[30:25], if_instr[11:8], 1'b0};
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                end
            end
            `OPC_JAL: begin
                op       = rv_pkg::OP_JAL;
                imm      = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                            if_instr[20], if_instr[30:21], 1'b0};
                rd_valid = 1'b1;
            end
            default: begin
                op = rv_pkg::OP_NOP;
            end
        endcase
    end

    register_file u_register_file (
        .clk       (clk),
        .rs1_addr  (rs1),
        .rs2_addr  (rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (wb_en),
        .wr_addr   (wb_rd),
        .wr_value  (wb_value)
    );

    // Load-use check against the instruction now in execute
    assign ex_rd       = id_ex.rd;
    assign ex_rd_valid = id_ex.rd_valid;
    assign ex_is_load  = (id_ex.op == rv_pkg::OP_LW);

    assign load_stall = ex_is_load && ex_rd_valid && ex_rd != '0 &&
                        ((rs1_used && rs1 == ex_rd) || (rs2_used && rs2 == ex_rd));

    // Control fields of ID/EX, bubble on flush or stall
    always_ff @(posedge clk) begin
        if (rst || redirect || load_stall) begin
            id_ex.op       <= rv_pkg::OP_NOP;
            id_ex.rs1_used <= 1'b0;
            id_ex.rs2_used <= 1'b0;
            id_ex.rd_valid <= 1'b0;
        end else begin
            id_ex.op       <= op;
            id_ex.rs1_used <= rs1_used;
            id_ex.rs2_used <= rs2_used;
            id_ex.rd_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc        <= if_pc;
        id_ex.rs1       <= rs1;
        id_ex.rs2       <= rs2;
        id_ex.rd        <= rd;
        id_ex.imm       <= imm;
        id_ex.rs1_value <= rs1_value;
        id_ex.rs2_value <= rs2_value;
    end

    // A stall holds IF/ID for one cycle only
    assert property (@(posedge clk) disable iff (rst)
        load_stall |=> ($stable(if_pc) && $stable(if_instr) && !load_stall))
        else $error("IF/ID not held for exactly one stall cycle");

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_stage (
    input  logic             clk,
    input  logic             rst,
    id_ex_if.sink            id_ex,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_value,
    output logic             redirect,
    output rv_pkg::addr_t    redirect_pc,
    ex_mem_if.source         ex_mem
);

    logic             mem_fwd_ok;
    rv_pkg::fwd_sel_t fwd_a;
    rv_pkg::fwd_sel_t fwd_b;
    rv_pkg::word_t    src_a;
    rv_pkg::word_t    src_b;
    rv_pkg::word_t    alu_result;
    logic             operands_equal;

    // A load in EX/MEM only has its address, never forward it
    assign mem_fwd_ok = ex_mem.rd_valid && ex_mem.rd != '0 && ex_mem.op != rv_pkg::OP_LW;

    function automatic rv_pkg::fwd_sel_t pick_source(input rv_pkg::reg_idx_t src,
                                                     input logic used);
        if (!used || src == '0) begin
            return rv_pkg::FWD_NONE;
        end
        // Youngest producer wins
        if (mem_fwd_ok && ex_mem.rd == src) begin
            return rv_pkg::FWD_MEM;
        end
        if (wb_en && wb_rd == src) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    function automatic rv_pkg::word_t select_operand(input rv_pkg::fwd_sel_t sel,
                                                     input rv_pkg::word_t reg_value);
        case (sel)
            rv_pkg::FWD_MEM: return ex_mem.result;
            rv_pkg::FWD_WB:  return wb_value;
            default:         return reg_value;
        endcase
    endfunction

    assign fwd_a = pick_source(id_ex.rs1, id_ex.rs1_used);
    assign fwd_b = pick_source(id_ex.rs2, id_ex.rs2_used);
    assign src_a = select_operand(fwd_a, id_ex.rs1_value);
    assign src_b = select_operand(fwd_b, id_ex.rs2_value);

    always_comb begin
        case (id_ex.op)
            rv_pkg::OP_LUI:  alu_result = id_ex.imm;
            rv_pkg::OP_ADDI,
            rv_pkg::OP_LW,
            rv_pkg::OP_SW:   alu_result = src_a + id_ex.imm;
            rv_pkg::OP_ADD:  alu_result = src_a + src_b;
            rv_pkg::OP_SUB:  alu_result = src_a - src_b;
            rv_pkg::OP_AND:  alu_result = src_a & src_b;
            rv_pkg::OP_OR:   alu_result = src_a | src_b;
            rv_pkg::OP_XOR:  alu_result = src_a ^ src_b;
            rv_pkg::OP_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            // Link address
            rv_pkg::OP_JAL:  alu_result = id_ex.pc + `XLEN'd4;
            default:         alu_result = '0;
        endcase
    end

    // Branch resolution
    assign operands_equal = (src_a == src_b);
    assign redirect = (id_ex.op == rv_pkg::OP_JAL) ||
                      (id_ex.op == rv_pkg::OP_BEQ && operands_equal) ||
                      (id_ex.op == rv_pkg::OP_BNE && !operands_equal);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.op       <= rv_pkg::OP_NOP;
            ex_mem.rd_valid <= 1'b0;
        end else begin
            ex_mem.op       <= id_ex.op;
            ex_mem.rd_valid <= id_ex.rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.rd         <= id_ex.rd;
        ex_mem.result     <= alu_result;
        ex_mem.store_data <= src_b;
    end

    // The instruction behind a taken branch or jump never reaches execute
    assert property (@(posedge clk) disable iff (rst)
        redirect |=> id_ex.op == rv_pkg::OP_NOP)
        else $error("instruction behind a redirect not squashed");

endmodule

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module memory_stage (
    input  logic             clk,
    input  logic             rst,
    ex_mem_if.sink           ex_mem,
    input  rv_pkg::word_t    read_data_in,
    output logic             mem_wr_en,
    output logic             mem_rd_en,
    output rv_pkg::addr_t    read_addr,
    output rv_pkg::addr_t    write_addr,
    output rv_pkg::word_t    wr_data,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_value
);

    rv_pkg::op_t      mem_wb_op;
    rv_pkg::reg_idx_t mem_wb_rd;
    logic             mem_wb_rd_valid;
    rv_pkg::word_t    mem_wb_result;

    // Data port, straight from EX/MEM
    assign mem_wr_en  = (ex_mem.op == rv_pkg::OP_SW);
    assign mem_rd_en  = (ex_mem.op == rv_pkg::OP_LW);
    assign read_addr  = ex_mem.result;
    assign write_addr = ex_mem.result;
    assign wr_data    = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_op       <= rv_pkg::OP_NOP;
            mem_wb_rd_valid <= 1'b0;
        end else begin
            mem_wb_op       <= ex_mem.op;
            mem_wb_rd_valid <= ex_mem.rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_rd     <= ex_mem.rd;
        mem_wb_result <= ex_mem.result;
    end

    // Load data arrives one cycle after the read strobe
    assign wb_value = (mem_wb_op == rv_pkg::OP_LW) ? read_data_in : mem_wb_result;
    assign wb_rd    = mem_wb_rd;
    assign wb_en    = mem_wb_rd_valid && mem_wb_rd != '0;

    // Stores never name a destination register
    assert property (@(posedge clk) disable iff (rst) mem_wr_en |-> !ex_mem.rd_valid)
        else $error("store carries a destination register");

endmodule

// File: verilog/riscv_cpu.sv
`timescale 1ns/1ps

module riscv_cpu (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr_in,
    input  logic [31:0] read_data_in,
    output logic [31:0] pc_out,
    output logic [31:0] wr_data_out,
    output logic        mem_wr_en,
    output logic        mem_rd_en,
    output logic [31:0] read_addr,
    output logic [31:0] write_addr
);

    logic        redirect;
    logic [31:0] redirect_pc;
    logic        load_stall;
    logic [31:0] if_pc;
    logic [31:0] if_instr;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .load_stall  (load_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_in    (instr_in),
        .pc          (pc_out),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .if_pc      (if_pc),
        .if_instr   (if_instr),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value),
        .load_stall (load_stall),
        .id_ex      (id_ex.source)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst         (rst),
        .id_ex       (id_ex.sink),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem.source)
    );

    memory_stage u_memory (
        .clk          (clk),
        .rst          (rst),
        .ex_mem       (ex_mem.sink),
        .read_data_in (read_data_in),
        .mem_wr_en    (mem_wr_en),
        .mem_rd_en    (mem_rd_en),
        .read_addr    (read_addr),
        .write_addr   (write_addr),
        .wr_data      (wr_data_out),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_value     (wb_value)
    );

endmodule

// File: bench/tb_riscv_cpu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_riscv_cpu;

    localparam int          CYCLE_LIMIT = 400;
    localparam int          STORE_COUNT = 12;
    // pc_out while the ADD after the LW waits in decode
    localparam logic [31:0] STALL_PC    = 32'h0000_0050;

    logic                   clk;
    logic                   rst;
    logic [31:0]            instr_in;
    logic [31:0]            read_data_in;
    logic [31:0]            pc_out;
    logic [31:0]            wr_data_out;
    logic                   mem_wr_en;
    logic                   mem_rd_en;
    logic [31:0]            read_addr;
    logic [31:0]            write_addr;

    logic [31:0]            imem [0:63];
    logic [31:0]            dmem [0:127];
    logic [31:0]            exp_addr [0:STORE_COUNT-1];
    logic [31:0]            exp_data [0:STORE_COUNT-1];
    logic [STORE_COUNT-1:0] store_seen;
    logic [31:0]            pc_prev;
    logic                   reset_q;
    int                     cycle_count;
    int                     stall_count;
    int                     jump_count;
    int                     seed;

    riscv_cpu UUT (
        .clk          (clk),
        .rst          (rst),
        .instr_in     (instr_in),
        .read_data_in (read_data_in),
        .pc_out       (pc_out),
        .wr_data_out  (wr_data_out),
        .mem_wr_en    (mem_wr_en),
        .mem_rd_en    (mem_rd_en),
        .read_addr    (read_addr),
        .write_addr   (write_addr)
    );

    always #4 clk = ~clk;

    // Instruction encoders
    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, `F3_ADD_SUB, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, `F3_WORD, rd, `OPC_LOAD};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic int find_store(input logic [31:0] addr);
        for (int i = 0; i < STORE_COUNT; i++) begin
            if (exp_addr[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Known address, right data, and not written before
    function automatic logic store_expected(input logic [31:0] addr, input logic [31:0] data,
                                            input logic [STORE_COUNT-1:0] seen);
        int idx;
        idx = find_store(addr);
        return idx >= 0 && exp_data[idx] == data && !seen[idx];
    endfunction

    function automatic logic all_stores_seen();
        for (int i = 0; i < STORE_COUNT; i++) begin
            if (!store_seen[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // BEQ at 0x64 lands on 0x74, JAL at 0x7C lands on 0x8C
    function automatic logic is_redirect_target(input logic [31:0] from, input logic [31:0] to);
        return (from == 32'h64 && to == 32'h74) || (from == 32'h7C && to == 32'h8C);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        fail_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    assign instr_in = imem[pc_out[7:2]];

    // Data RAM with one cycle of read latency
    always @(posedge clk) begin
        if (mem_wr_en) begin
            dmem[write_addr[8:2]] <= wr_data_out;
        end
        if (mem_rd_en) begin
            read_data_in <= #1 dmem[read_addr[8:2]];
        end
    end

    always @(posedge clk) begin
        int idx;
        reset_q <= rst;
        pc_prev <= pc_out;
        if (!rst) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count >= 1 && pc_out == pc_prev) begin
            stall_count <= stall_count + 1;
        end
        if (cycle_count >= 1 && pc_out != pc_prev && pc_out != pc_prev + 32'd4) begin
            jump_count <= jump_count + 1;
        end
        if (mem_wr_en) begin
            idx = find_store(write_addr);
            if (idx >= 0) begin
                store_seen[idx] <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) reset_q |-> (pc_out == `RESET_PC && !mem_wr_en && !mem_rd_en))
        else report_mismatch($sformatf("pc_out %h or a memory strobe wrong around reset",
                                       $sampled(pc_out)));

    assert property (@(posedge clk)
        mem_wr_en |-> store_expected(write_addr, wr_data_out, store_seen))
        else report_mismatch($sformatf("store of %h to %h not expected",
                                       $sampled(wr_data_out), $sampled(write_addr)));

    // The program loads only from 0x80 and 0x84
    assert property (@(posedge clk) mem_rd_en |-> (read_addr == 32'h80 || read_addr == 32'h84))
        else report_mismatch($sformatf("load from %h not expected", $sampled(read_addr)));

    assert property (@(posedge clk) (cycle_count >= 1 && pc_out == $past(pc_out))
        |-> pc_out == STALL_PC)
        else report_mismatch($sformatf("pc_out held at %h", $sampled(pc_out)));

    assert property (@(posedge clk) (cycle_count >= 1 && pc_out == $past(pc_out))
        |=> pc_out != $past(pc_out))
        else report_mismatch("pc_out held for more than one cycle");

    assert property (@(posedge clk)
        (cycle_count >= 1 && pc_out != $past(pc_out) && pc_out != $past(pc_out) + 32'd4)
        |-> is_redirect_target($past(pc_out, 3), pc_out))
        else report_mismatch($sformatf("pc_out jumped to %h", $sampled(pc_out)));

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        read_data_in = '0;
        reset_q      = 1'b0;
        pc_prev      = '0;
        cycle_count  = 0;
        stall_count  = 0;
        jump_count   = 0;
        seed         = 44;

        for (int i = 0; i < 64; i++) begin
            imem[i] = addi(5'd0, 5'd0, 12'(i * 4));
        end
        for (int i = 0; i < 128; i++) begin
            dmem[i] = 32'h5A00_0000 | 32'(i * 4);
        end
        dmem[32] = $random(seed);
        dmem[33] = $random(seed);

        // ALU block, dependences at distance one, two and three
        imem[0]  = lui(5'd1, 20'h12345);
        imem[1]  = addi(5'd2, 5'd0, 12'd100);
        imem[2]  = addi(5'd3, 5'd0, 12'hFF9);
        imem[3]  = reg_op(`F7_BASE, `F3_ADD_SUB, 5'd4, 5'd2, 5'd3);
        imem[4]  = reg_op(`F7_SUB, `F3_ADD_SUB, 5'd5, 5'd4, 5'd1);
        imem[5]  = reg_op(`F7_BASE, `F3_AND, 5'd6, 5'd5, 5'd3);
        imem[6]  = reg_op(`F7_BASE, `F3_OR, 5'd7, 5'd4, 5'd2);
        imem[7]  = reg_op(`F7_BASE, `F3_XOR, 5'd8, 5'd7, 5'd1);
        imem[8]  = reg_op(`F7_BASE, `F3_SLT, 5'd9, 5'd3, 5'd2);
        imem[9]  = reg_op(`F7_BASE, `F3_SLT, 5'd10, 5'd2, 5'd3);
        imem[10] = sw(5'd1, 5'd0, 12'h100);
        imem[11] = sw(5'd4, 5'd0, 12'h104);
        imem[12] = sw(5'd5, 5'd0, 12'h108);
        imem[13] = sw(5'd6, 5'd0, 12'h10C);
        imem[14] = sw(5'd7, 5'd0, 12'h110);
        imem[15] = sw(5'd8, 5'd0, 12'h114);
        imem[16] = sw(5'd9, 5'd0, 12'h118);
        imem[17] = sw(5'd10, 5'd0, 12'h11C);
        // Load-use stall, then a load consumed two slots later
        imem[18] = lw(5'd12, 5'd0, 12'h080);
        imem[19] = reg_op(`F7_BASE, `F3_ADD_SUB, 5'd13, 5'd12, 5'd2);
        imem[20] = sw(5'd13, 5'd0, 12'h120);
        imem[21] = lw(5'd14, 5'd0, 12'h084);
        imem[22] = addi(5'd15, 5'd0, 12'h023);
        imem[23] = reg_op(`F7_SUB, `F3_ADD_SUB, 5'd16, 5'd14, 5'd15);
        imem[24] = sw(5'd16, 5'd0, 12'h124);
        // Taken BEQ skips three stores, first two sit in squashed slots
        imem[25] = branch(`F3_BEQ, 5'd2, 5'd2, 13'd16);
        imem[26] = sw(5'd2, 5'd0, 12'h180);
        imem[27] = sw(5'd2, 5'd0, 12'h184);
        imem[28] = sw(5'd2, 5'd0, 12'h188);
        imem[29] = branch(`F3_BNE, 5'd2, 5'd2, 13'd8);
        imem[30] = sw(5'd3, 5'd0, 12'h128);
        imem[31] = jal(5'd17, 21'd16);
        imem[32] = sw(5'd2, 5'd0, 12'h18C);
        imem[33] = sw(5'd2, 5'd0, 12'h190);
        imem[34] = sw(5'd2, 5'd0, 12'h194);
        imem[35] = sw(5'd17, 5'd0, 12'h12C);

        // Worked out by hand from the program above
        exp_data[0]  = 32'h1234_5000;
        exp_data[1]  = 32'h0000_005D;
        exp_data[2]  = 32'hEDCB_B05D;
        exp_data[3]  = 32'hEDCB_B059;
        exp_data[4]  = 32'h0000_007D;
        exp_data[5]  = 32'h1234_507D;
        exp_data[6]  = 32'h0000_0001;
        exp_data[7]  = 32'h0000_0000;
        exp_data[8]  = dmem[32] + 32'd100;
        exp_data[9]  = dmem[33] - 32'h23;
        exp_data[10] = 32'hFFFF_FFF9;
        exp_data[11] = 32'h0000_0080;
        for (int i = 0; i < STORE_COUNT; i++) begin
            exp_addr[i]   = 32'h100 + 32'(i * 4);
            store_seen[i] = 1'b0;
        end

        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        do begin
            @(posedge clk);
            #1;
        end while (!all_stores_seen() && cycle_count <= CYCLE_LIMIT);

        if (cycle_count > CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout: stores still missing after %0d cycles", CYCLE_LIMIT));
        end else if (stall_count != 1) begin
            report_mismatch($sformatf("saw %0d load-use stalls instead of one", stall_count));
        end else if (jump_count != 2) begin
            report_mismatch($sformatf("saw %0d redirects instead of two", jump_count));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/id_ex_if.sv
verilog/ex_mem_if.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/riscv_cpu.sv
bench/tb_riscv_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_cpu
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
